/* design/core_readback.sv */
// global readback mux
// picks the status or constant word by select and registers it

`timescale 1ns/1ps
`default_nettype none

module core_readback
  import core_regs_pkg::*;
(
  input  wire        i_bus_clk,
  input  wire        i_bus_rst,
  input  wire [4:0]  i_sel,
  input  wire [31:0] i_test,
  input  lock_stat_t i_lock,
  input  wire [1:0]  i_pps_select,
  input  wire [3:0]  i_tcxo_status,
  output logic [31:0] o_rb_data
);

  logic [31:0] misc_word;
  logic [31:0] pll_word;
  logic [31:0] rb_next;

  // tcxo status above the pps source
  assign misc_word = {26'd0, i_tcxo_status, i_pps_select};
  assign pll_word  = {28'd0, i_lock};

  //////////////////////////////////////////////////
  // word select
  //////////////////////////////////////////////////
  always_comb begin
    case (i_sel)
      RB_CORE_TEST:    rb_next = i_test;
      RB_CORE_MISC:    rb_next = misc_word;
      RB_CORE_COMPAT:  rb_next = CORE_COMPAT;
      RB_CORE_GITHASH: rb_next = CORE_GITHASH;
      RB_CORE_PLL:     rb_next = pll_word;
      RB_CORE_NUMCE:   rb_next = 32'(CORE_NUM_CE);
      default:         rb_next = RB_DEFAULT;
    endcase
  end

  // one cycle of latency on every word
  always_ff @(posedge i_bus_clk) begin
    if (i_bus_rst) begin
      o_rb_data <= '0;
    end else begin
      o_rb_data <= rb_next;
    end
  end

endmodule

`default_nettype wire

/* design/core_regs_pkg.sv */
// global register definitions for the sdr core
// settings offsets, readback selects, constants and bus structs

`default_nettype none

package core_regs_pkg;

  //////////////////////////////////////////////////
  // settings bus word offsets
  //////////////////////////////////////////////////
  localparam logic [10:0] SR_CORE_READBACK = 11'd0;
  localparam logic [10:0] SR_CORE_MISC     = 11'd4;
  localparam logic [10:0] SR_CORE_PLL_CLR  = 11'd8;
  localparam logic [10:0] SR_CORE_TEST     = 11'd28;
  localparam logic [10:0] SR_CORE_XB_LOCAL = 11'd32;

  //////////////////////////////////////////////////
  // readback selects
  //////////////////////////////////////////////////
  localparam logic [4:0] RB_CORE_MISC    = 5'd1;
  localparam logic [4:0] RB_CORE_COMPAT  = 5'd2;
  localparam logic [4:0] RB_CORE_GITHASH = 5'd3;
  localparam logic [4:0] RB_CORE_PLL     = 5'd4;
  localparam logic [4:0] RB_CORE_NUMCE   = 5'd8;
  localparam logic [4:0] RB_CORE_TEST    = 5'd24;

  // fixed readback words
  localparam logic [31:0] CORE_COMPAT  = 32'hAC00_0700;
  localparam logic [31:0] CORE_GITHASH = 32'h5E3A_91C7;
  localparam int unsigned CORE_NUM_CE  = 2;
  localparam logic [31:0] RB_DEFAULT   = 32'hDEAD_BEEF;

  // crossbar address out of reset
  localparam logic [7:0] XB_LOCAL_RESET = 8'd40;

  // one settings bus beat
  typedef struct packed {
    logic        stb;
    logic [31:0] addr;
    logic [31:0] data;
  } set_bus_t;

  // decoded write strobes, one hot or idle
  typedef struct packed {
    logic readback;
    logic misc;
    logic test;
    logic xb_local;
    logic lock_clr;
  } set_wr_t;

  // front-end controls, msb field first so pps_select lands at bit 0
  typedef struct packed {
    logic [3:0] rx_bandsel_c;
    logic [3:0] rx_bandsel_b;
    logic [5:0] rx_bandsel_a;
    logic [2:0] tx_bandsel;
    logic       codec_arst;
    logic       mimo;
    logic [1:0] pps_select;
  } misc_ctrl_t;

  // internal pps as default source
  localparam misc_ctrl_t MISC_RESET = '{
    rx_bandsel_c: 4'd0,
    rx_bandsel_b: 4'd0,
    rx_bandsel_a: 6'd0,
    tx_bandsel:   3'd0,
    codec_arst:   1'b0,
    mimo:         1'b0,
    pps_select:   2'd2
  };

  // pll status word, lost flags above locked bits
  typedef struct packed {
    logic [1:0] lost;
    logic [1:0] locked;
  } lock_stat_t;

endpackage

`default_nettype wire

/* design/core_set_decode.sv */
// settings bus decoder
// turns a strobed write into one register strobe or the lock clear

`timescale 1ns/1ps
`default_nettype none

module core_set_decode
  import core_regs_pkg::*;
(
  input  wire      i_bus_clk,
  input  wire      i_bus_rst,
  input  set_bus_t i_set,
  output set_wr_t  o_wr
);

  // word offset within the global register block
  logic [10:0] offset;
  logic        hit;

  // last address that matched no register, kept for debug
  logic [10:0] miss_addr;

  assign offset = i_set.addr[10:0];

  //////////////////////////////////////////////////
  // address compare
  //////////////////////////////////////////////////
  always_comb begin
    o_wr = '0;
    if (i_set.stb) begin
      case (offset)
        SR_CORE_READBACK: o_wr.readback = 1'b1;
        SR_CORE_MISC:     o_wr.misc     = 1'b1;
        SR_CORE_PLL_CLR:  o_wr.lock_clr = 1'b1;
        SR_CORE_TEST:     o_wr.test     = 1'b1;
        SR_CORE_XB_LOCAL: o_wr.xb_local = 1'b1;
        default:          o_wr          = '0;
      endcase
    end
  end

  assign hit = |o_wr;

  // unknown offsets are dropped, only the address is remembered
  always_ff @(posedge i_bus_clk) begin
    if (i_bus_rst) begin
      miss_addr <= '0;
    end else if (i_set.stb && !hit) begin
      miss_addr <= offset;
    end
  end

endmodule

`default_nettype wire

/* design/e300_core.sv */
// sdr core global registers
// settings decode, control registers, pll lock monitor and readback

`timescale 1ns/1ps
`default_nettype none

module e300_core
  import core_regs_pkg::*;
(
  input  wire        i_bus_clk,
  input  wire        i_bus_rst,

  // settings bus
  input  wire        i_set_stb,
  input  wire [31:0] i_set_addr,
  input  wire [31:0] i_set_data,

  // status inputs
  input  wire [1:0]  i_lock_signals,
  input  wire [3:0]  i_tcxo_status,

  output wire [31:0] o_rb_data,

  // front-end controls
  output wire [1:0]  o_pps_select,
  output wire        o_mimo,
  output wire        o_codec_arst,
  output wire [2:0]  o_tx_bandsel,
  output wire [5:0]  o_rx_bandsel_a,
  output wire [3:0]  o_rx_bandsel_b,
  output wire [3:0]  o_rx_bandsel_c,

  output wire [7:0]  o_xb_local_addr
);

  set_bus_t    set_bus;
  set_wr_t     set_wr;
  logic [4:0]  rb_sel;
  logic [31:0] test_word;
  misc_ctrl_t  misc_ctrl;
  lock_stat_t  lock_stat;

  assign set_bus.stb  = i_set_stb;
  assign set_bus.addr = i_set_addr;
  assign set_bus.data = i_set_data;

  //////////////////////////////////////////////////
  // settings decode and registers
  //////////////////////////////////////////////////
  core_set_decode u_decode (
    .i_bus_clk (i_bus_clk),
    .i_bus_rst (i_bus_rst),
    .i_set     (set_bus),
    .o_wr      (set_wr)
  );

  setting_reg #(.payload_t(logic [4:0]), .RESET_VAL(5'd0)) u_sr_readback (
    .i_bus_clk (i_bus_clk),
    .i_bus_rst (i_bus_rst),
    .i_wr      (set_wr.readback),
    .i_data    (set_bus.data),
    .o_value   (rb_sel)
  );

  setting_reg #(.payload_t(logic [31:0]), .RESET_VAL(32'd0)) u_sr_test (
    .i_bus_clk (i_bus_clk),
    .i_bus_rst (i_bus_rst),
    .i_wr      (set_wr.test),
    .i_data    (set_bus.data),
    .o_value   (test_word)
  );

  setting_reg #(.payload_t(misc_ctrl_t), .RESET_VAL(MISC_RESET)) u_sr_misc (
    .i_bus_clk (i_bus_clk),
    .i_bus_rst (i_bus_rst),
    .i_wr      (set_wr.misc),
    .i_data    (set_bus.data),
    .o_value   (misc_ctrl)
  );

  setting_reg #(.payload_t(logic [7:0]), .RESET_VAL(XB_LOCAL_RESET)) u_sr_xb_local (
    .i_bus_clk (i_bus_clk),
    .i_bus_rst (i_bus_rst),
    .i_wr      (set_wr.xb_local),
    .i_data    (set_bus.data),
    .o_value   (o_xb_local_addr)
  );

  //////////////////////////////////////////////////
  // status and readback
  //////////////////////////////////////////////////
  // clear mask rides in the low data bits
  pll_lock_mon u_lock_mon (
    .i_bus_clk  (i_bus_clk),
    .i_bus_rst  (i_bus_rst),
    .i_lock_raw (i_lock_signals),
    .i_clr      (set_wr.lock_clr),
    .i_clr_mask (set_bus.data[1:0]),
    .o_stat     (lock_stat)
  );

  core_readback u_readback (
    .i_bus_clk     (i_bus_clk),
    .i_bus_rst     (i_bus_rst),
    .i_sel         (rb_sel),
    .i_test        (test_word),
    .i_lock        (lock_stat),
    .i_pps_select  (misc_ctrl.pps_select),
    .i_tcxo_status (i_tcxo_status),
    .o_rb_data     (o_rb_data)
  );

  // misc fan out
  assign o_pps_select   = misc_ctrl.pps_select;
  assign o_mimo         = misc_ctrl.mimo;
  assign o_codec_arst   = misc_ctrl.codec_arst;
  assign o_tx_bandsel   = misc_ctrl.tx_bandsel;
  assign o_rx_bandsel_a = misc_ctrl.rx_bandsel_a;
  assign o_rx_bandsel_b = misc_ctrl.rx_bandsel_b;
  assign o_rx_bandsel_c = misc_ctrl.rx_bandsel_c;

endmodule

`default_nettype wire

/* design/pll_lock_mon.sv */
// pll lock monitor
// syncs the two lock inputs and keeps sticky loss-of-lock flags

`timescale 1ns/1ps
`default_nettype none

module pll_lock_mon
  import core_regs_pkg::*;
(
  input  wire        i_bus_clk,
  input  wire        i_bus_rst,
  input  wire [1:0]  i_lock_raw,
  input  wire        i_clr,
  input  wire [1:0]  i_clr_mask,
  output lock_stat_t o_stat
);

  //////////////////////////////////////////////////
  // two flop synchronizer
  //////////////////////////////////////////////////
  logic [1:0] lock_meta;
  logic [1:0] lock_sync;

  // previous synchronized level, for edge detect
  logic [1:0] lock_prev;
  logic [1:0] lock_fall;
  logic [1:0] clr_bits;
  logic [1:0] lost;

  always_ff @(posedge i_bus_clk) begin
    if (i_bus_rst) begin
      lock_meta <= '0;
      lock_sync <= '0;
      lock_prev <= '0;
    end else begin
      lock_meta <= i_lock_raw;
      lock_sync <= lock_meta;
      lock_prev <= lock_sync;
    end
  end

  assign lock_fall = lock_prev & ~lock_sync;
  assign clr_bits  = i_clr ? i_clr_mask : 2'b00;

  // a new fall beats a clear in the same cycle
  always_ff @(posedge i_bus_clk) begin
    if (i_bus_rst) begin
      lost <= '0;
    end else begin
      lost <= (lost & ~clr_bits) | lock_fall;
    end
  end

  assign o_stat.locked = lock_sync;
  assign o_stat.lost   = lost;

endmodule

`default_nettype wire

/* design/setting_reg.sv */
// addressed settings register
// loads the low payload bits of the settings data on its strobe

`timescale 1ns/1ps
`default_nettype none

module setting_reg #(
  parameter type      payload_t = logic [31:0],
  parameter payload_t RESET_VAL = '0
) (
  input  wire        i_bus_clk,
  input  wire        i_bus_rst,
  input  wire        i_wr,
  input  wire [31:0] i_data,
  output payload_t   o_value
);

  localparam int unsigned PAYLOAD_W = $bits(payload_t);

  // payload slice of the bus word
  logic [PAYLOAD_W-1:0] data_bits;

  assign data_bits = i_data[PAYLOAD_W-1:0];

  always_ff @(posedge i_bus_clk) begin
    if (i_bus_rst) begin
      o_value <= RESET_VAL;
    end else if (i_wr) begin
      o_value <= payload_t'(data_bits);
    end
  end

endmodule

`default_nettype wire

/* e300_core.f */
design/core_regs_pkg.sv
design/core_set_decode.sv
design/setting_reg.sv
design/pll_lock_mon.sv
design/core_readback.sv
design/e300_core.sv
verif/e300_core_assertions.sv
verif/e300_core_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the e300_core testbench with Verilator.
# Exits non-zero when the build fails, the simulation fails,
# or the log does not report a pass.

cd "$(dirname "$0")" || exit 1

TOP=e300_core_tb
OBJ_DIR=obj_dir
LOG=sim.log

echo "building $TOP"
verilator --binary --timing --assert \
  --top-module "$TOP" \
  -Mdir "$OBJ_DIR" \
  -f e300_core.f
status=$?
if [ $status -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit 1
fi

echo "running $TOP"
"./$OBJ_DIR/V$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -qx "RESULT: PASS" "$LOG"; then
  echo "simulation passed"
  exit 0
else
  echo "simulation did not pass, see $LOG"
  exit 1
fi

/* verif/e300_core_assertions.sv */
// bound checks for the settings decoder and registers
// strobe exclusivity, miss capture and values out of reset

`timescale 1ns/1ps
`default_nettype none

module e300_core_assertions #(
  parameter int unsigned N_STB = 1
) (
  input wire             i_bus_clk,
  input wire             i_bus_rst,
  input wire             i_stb,
  input wire [N_STB-1:0] i_wr,
  input wire [10:0]      i_addr,
  input wire [10:0]      i_miss_addr,
  input wire             i_at_reset_val
);

  // register holds its reset value right after a reset cycle
  a_reset_value: assert property (
    @(posedge i_bus_clk) i_bus_rst |=> i_at_reset_val
  ) else $error("register output differs from its reset value");

  //////////////////////////////////////////////////
  // decoder strobes and miss capture
  //////////////////////////////////////////////////
  if (N_STB > 1) begin : g_decode

    // decoded strobes are one hot or idle
    a_strobe_onehot: assert property (
      @(posedge i_bus_clk) disable iff (i_bus_rst) $onehot0(i_wr)
    ) else $error("more than one write strobe high");

    // no write without a bus strobe
    a_strobe_needs_stb: assert property (
      @(posedge i_bus_clk) disable iff (i_bus_rst) !i_stb |-> (i_wr == '0)
    ) else $error("write strobe high without a bus strobe");

    // an unmatched strobed offset is kept for debug
    a_miss_capture: assert property (
      @(posedge i_bus_clk) disable iff (i_bus_rst)
        i_stb && (i_wr == '0) |=> (i_miss_addr == $past(i_addr))
    ) else $error("unmatched offset was not captured");

  end

endmodule

bind core_set_decode e300_core_assertions #(.N_STB(5)) u_decode_sva (
  .i_bus_clk      (i_bus_clk),
  .i_bus_rst      (i_bus_rst),
  .i_stb          (i_set.stb),
  .i_wr           (o_wr),
  .i_addr         (offset),
  .i_miss_addr    (miss_addr),
  .i_at_reset_val (miss_addr == 11'd0)
);

bind setting_reg e300_core_assertions #(.N_STB(1)) u_reg_sva (
  .i_bus_clk      (i_bus_clk),
  .i_bus_rst      (i_bus_rst),
  .i_stb          (i_wr),
  .i_wr           (i_wr),
  .i_addr         (11'd0),
  .i_miss_addr    (11'd0),
  .i_at_reset_val (o_value == RESET_VAL)
);

`default_nettype wire

/* verif/e300_core_cases.txt */
// columns: kind a b c, all hex
// kind 1 write addr data | 2 lock level | 3 readback sel word ctrl | 4 write addr data ctrl
// ctrl word: xb_local in bits 28:21, misc fields in bits 20:0
// out of reset
3 00 deadbeef 05000002
3 01 00000026 05000002
3 04 00000000 05000002
3 18 00000000 05000002
// misc fields, upper data bits ignored
4 04 ffed355d 050d355d
3 01 00000025 050d355d
// test word and constants
1 1c 13579bdf 0
3 18 13579bdf 050d355d
3 02 ac000700 050d355d
3 03 5e3a91c7 050d355d
3 08 00000002 050d355d
// unknown selects
3 05 deadbeef 050d355d
3 10 deadbeef 050d355d
3 1f deadbeef 050d355d
// unused offsets
1 0c ffffffff 0
1 14 ffffffff 0
1 24 ffffffff 0
1 7fc ffffffff 0
3 18 13579bdf 050d355d
3 01 00000025 050d355d
3 04 00000000 050d355d
// only the low 11 address bits decode
1 4000001c 2468ace0 0
3 18 2468ace0 050d355d
// lock, loss, relock and masked clear
2 1 0 0
3 04 00000001 050d355d
2 3 0 0
3 04 00000003 050d355d
2 2 0 0
3 04 00000006 050d355d
2 3 0 0
3 04 00000007 050d355d
2 0 0 0
3 04 0000000c 050d355d
1 08 00000001 0
3 04 00000008 050d355d
2 3 0 0
3 04 0000000b 050d355d
1 08 00000002 0
3 04 00000003 050d355d
// crossbar address and all misc bits set
4 20 000001a5 14ad355d
4 04 001fffff 14bfffff
3 01 00000027 14bfffff
4 20 00000028 051fffff
3 00 deadbeef 051fffff

/* verif/e300_core_tb.sv */
// testbench for the sdr core global registers
// replays write, lock and readback cases from a data file

`timescale 1ns/1ps
`default_nettype none

module e300_core_tb
  import core_regs_pkg::*;
();

  localparam int          RESET_CYCLES    = 16;
  localparam int          CYCLES_PER_CASE = 20;
  localparam int          MAX_CASES       = 64;
  localparam logic [3:0]  TCXO_STATUS     = 4'h9;
  // pps select 2 and crossbar address 40, everything else clear
  localparam logic [31:0] RESET_CTRL      = 32'h0500_0002;

  logic        bus_clk;
  logic        bus_rst;
  logic        set_stb;
  logic [31:0] set_addr;
  logic [31:0] set_data;
  logic [1:0]  lock_signals;
  logic [3:0]  tcxo_status;

  wire  [31:0] rb_data;
  wire  [1:0]  pps_select;
  wire         mimo;
  wire         codec_arst;
  wire  [2:0]  tx_bandsel;
  wire  [5:0]  rx_bandsel_a;
  wire  [3:0]  rx_bandsel_b;
  wire  [3:0]  rx_bandsel_c;
  wire  [7:0]  xb_local_addr;

  // four words per case: kind, then three arguments
  logic [31:0] case_mem [0:4*MAX_CASES-1];
  int          num_cases;
  int          mismatch_count;
  int          other_count;
  logic [31:0] rng_state;

  e300_core i_e300_core (
    .i_bus_clk       (bus_clk),
    .i_bus_rst       (bus_rst),
    .i_set_stb       (set_stb),
    .i_set_addr      (set_addr),
    .i_set_data      (set_data),
    .i_lock_signals  (lock_signals),
    .i_tcxo_status   (tcxo_status),
    .o_rb_data       (rb_data),
    .o_pps_select    (pps_select),
    .o_mimo          (mimo),
    .o_codec_arst    (codec_arst),
    .o_tx_bandsel    (tx_bandsel),
    .o_rx_bandsel_a  (rx_bandsel_a),
    .o_rx_bandsel_b  (rx_bandsel_b),
    .o_rx_bandsel_c  (rx_bandsel_c),
    .o_xb_local_addr (xb_local_addr)
  );

  initial bus_clk = 1'b0;
  always #2 bus_clk = ~bus_clk;

  //////////////////////////////////////////////////
  // helpers
  //////////////////////////////////////////////////
  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected) begin
      mismatch_count++;
      $display("Mismatch at %0t: %s expected %08h actual %08h", $time, name, expected, actual);
    end
  endtask

  // ctrl word holds xb_local in 28:21 and the misc fields in 20:0
  task automatic check_controls(input logic [31:0] exp);
    check_value("o_pps_select", {30'd0, exp[1:0]}, {30'd0, pps_select});
    check_value("o_mimo", {31'd0, exp[2]}, {31'd0, mimo});
    check_value("o_codec_arst", {31'd0, exp[3]}, {31'd0, codec_arst});
    check_value("o_tx_bandsel", {29'd0, exp[6:4]}, {29'd0, tx_bandsel});
    check_value("o_rx_bandsel_a", {26'd0, exp[12:7]}, {26'd0, rx_bandsel_a});
    check_value("o_rx_bandsel_b", {28'd0, exp[16:13]}, {28'd0, rx_bandsel_b});
    check_value("o_rx_bandsel_c", {28'd0, exp[20:17]}, {28'd0, rx_bandsel_c});
    check_value("o_xb_local_addr", {24'd0, exp[28:21]}, {24'd0, xb_local_addr});
  endtask

  task automatic idle_gap();
    int unsigned gap;
    rng_state = xorshift32(rng_state);
    gap = rng_state % 4;
    repeat (gap) @(posedge bus_clk);
  endtask

  // returns on the edge that samples the strobe
  task automatic bus_write(input logic [31:0] addr, input logic [31:0] data);
    idle_gap();
    @(posedge bus_clk);
    set_stb  <= 1'b1;
    set_addr <= addr;
    set_data <= data;
    @(posedge bus_clk);
    set_stb  <= 1'b0;
  endtask

  task automatic set_lock_level(input logic [1:0] level);
    @(posedge bus_clk);
    lock_signals <= level;
    // two sync edges to locked, one more for a lost flag
    repeat (3) @(posedge bus_clk);
  endtask

  // select lands one edge after the strobe, data one edge later
  task automatic check_readback(input logic [31:0] sel, input logic [31:0] exp_rb,
                                input logic [31:0] exp_ctrl);
    bus_write({21'd0, SR_CORE_READBACK}, sel);
    @(posedge bus_clk);
    @(negedge bus_clk);
    check_value("o_rb_data", exp_rb, rb_data);
    check_controls(exp_ctrl);
  endtask

  //////////////////////////////////////////////////
  // main sequence
  //////////////////////////////////////////////////
  initial begin
    int          idx;
    logic [7:0]  base;
    logic [31:0] kind;
    mismatch_count = 0;
    other_count    = 0;
    rng_state      = 32'd56657;
    bus_rst        = 1'b1;
    set_stb        = 1'b0;
    set_addr       = '0;
    set_data       = '0;
    lock_signals   = 2'b00;
    tcxo_status    = TCXO_STATUS;

    case_mem = '{default: '0};
    $readmemh("verif/e300_core_cases.txt", case_mem);
    num_cases = 0;
    while (num_cases < MAX_CASES && case_mem[8'(4 * num_cases)] != 32'd0) begin
      num_cases++;
    end
    if (num_cases == 0) begin
      other_count++;
      $display("no cases could be read from verif/e300_core_cases.txt");
    end

    repeat (RESET_CYCLES - 1) @(posedge bus_clk);
    @(negedge bus_clk);
    check_value("o_rb_data", 32'h0, rb_data);
    check_controls(RESET_CTRL);
    @(posedge bus_clk);
    bus_rst <= 1'b0;

    for (idx = 0; idx < num_cases; idx++) begin
      base = 8'(4 * idx);
      kind = case_mem[base];
      case (kind)
        32'd1: bus_write(case_mem[base + 8'd1], case_mem[base + 8'd2]);
        32'd2: set_lock_level(case_mem[base + 8'd1][1:0]);
        32'd3: check_readback(case_mem[base + 8'd1], case_mem[base + 8'd2],
                              case_mem[base + 8'd3]);
        32'd4: begin
          bus_write(case_mem[base + 8'd1], case_mem[base + 8'd2]);
          @(negedge bus_clk);
          check_controls(case_mem[base + 8'd3]);
        end
        default: begin
          other_count++;
          $display("case %0d has an unknown kind %0h", idx, kind);
        end
      endcase
    end

    repeat (2) @(posedge bus_clk);
    $display("errors: %0d mismatches, %0d other, %0d cases run",
             mismatch_count, other_count, num_cases);
    if (mismatch_count == 0 && other_count == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

  // one spare case length covers the reset checks
  initial begin
    repeat (RESET_CYCLES) @(posedge bus_clk);
    repeat (num_cases * CYCLES_PER_CASE + CYCLES_PER_CASE) @(posedge bus_clk);
    $display("timeout: the cases did not finish in time");
    $display("errors: %0d mismatches, %0d other, timed out",
             mismatch_count, other_count + 1);
    $display("RESULT: FAIL");
    $finish;
  end

endmodule

`default_nettype wire
